/* common/ucode_pkg.sv */
/* Shared widths, instruction field layout, opcodes and the sequencer state type.
   Imported by every block of the execution slice and by the testbench. */
`default_nettype none

package ucode_pkg;

    // Widths
    localparam int INSTR_W    = 32;
    localparam int OPCODE_W   = 6;
    localparam int REG_ADDR_W = 4;
    localparam int DATA_W     = 16;
    localparam int IMM_W      = 16;
    localparam int NUM_REGS   = 16;  // Size of the register file

    typedef logic [INSTR_W-1:0]    instr_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [IMM_W-1:0]      imm_t;

    // Field positions inside an instruction word
    localparam int OP_LSB  = 26;  // Opcode in bits 31..26
    localparam int RD_LSB  = 22;  // rd in bits 25..22
    localparam int RS1_LSB = 18;  // rs1 in bits 21..18
    localparam int RS2_LSB = 14;  // rs2 in bits 17..14, register form only
                                  // imm sits in bits 15..0, immediate form only

    // Opcodes, anything else executes as NOP
    localparam opcode_t OP_NOP  = 6'h00;
    localparam opcode_t OP_MOVI = 6'h10;  // rd = imm
    localparam opcode_t OP_MOV  = 6'h11;  // rd = rs1
    localparam opcode_t OP_ADD  = 6'h31;  // rd = rs1 + rs2
    localparam opcode_t OP_SUB  = 6'h32;  // rd = rs1 - rs2
    localparam opcode_t OP_MUL  = 6'h33;  // rd = rs1 * imm, expanded by microcode

    // Scratch register owned by the microcode sequencer
    localparam reg_addr_t UCODE_SCRATCH = 4'd15;

    // Sequencer control states
    typedef enum logic [1:0] {
        SEQ_IDLE,   // Waiting for a MUL in the decoder
        SEQ_COPY,   // MOV R15, rs1
        SEQ_CLEAR,  // SUB rd, rd, rd
        SEQ_ADD     // ADD rd, rd, R15, once per count
    } seq_state_t;

endpackage

`default_nettype wire

/* hdl/instr_decoder.sv */
/* One-entry input buffer for the instruction stream with valid/ready on both sides.
   The held word is split into fields for the issue stage and the sequencer. */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  in_valid,
    output logic                 in_ready,
    input  ucode_pkg::instr_t    in_instr,
    input  wire                  dec_ready,  // Plain instruction taken by issue
    input  wire                  mul_ack,    // MUL taken by the sequencer
    output logic                 dec_valid,
    output logic                 dec_is_mul,
    output ucode_pkg::opcode_t   dec_op,
    output ucode_pkg::reg_addr_t dec_rd,
    output ucode_pkg::reg_addr_t dec_rs1,
    output ucode_pkg::reg_addr_t dec_rs2,
    output ucode_pkg::imm_t      dec_imm
);
    import ucode_pkg::*;

    logic   held_valid;
    instr_t held_instr;
    logic   entry_free;  // Entry is consumed on this edge

    assign entry_free = dec_ready | mul_ack;
    assign in_ready   = ~held_valid | entry_free;  // Refill allowed on the freeing edge

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (in_ready) begin
            held_valid <= in_valid;  // Empty out or take the next word
        end
    end

    // Instruction word, only loaded on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held_instr <= in_instr;
        end
    end

    // Field split
    assign dec_valid  = held_valid;
    assign dec_op     = held_instr[OP_LSB +: OPCODE_W];
    assign dec_rd     = held_instr[RD_LSB +: REG_ADDR_W];
    assign dec_rs1    = held_instr[RS1_LSB +: REG_ADDR_W];
    assign dec_rs2    = held_instr[RS2_LSB +: REG_ADDR_W];
    assign dec_imm    = held_instr[IMM_W-1:0];
    assign dec_is_mul = (dec_op == OP_MUL);  // Only MUL test in the design

endmodule

`default_nettype wire

/* ucode/ucode_sequencer.sv */
/* Microcode sequencer that expands MUL rd, rs1, #imm into register micro-ops.
   Emits MOV R15,rs1 then SUB rd,rd,rd then imm times ADD rd,rd,R15, one per cycle. */
`timescale 1ns/1ps
`default_nettype none

module ucode_sequencer (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  dec_valid,
    input  wire                  dec_is_mul,
    input  ucode_pkg::reg_addr_t dec_rd,
    input  ucode_pkg::reg_addr_t dec_rs1,
    input  ucode_pkg::imm_t      dec_imm,
    output logic                 mul_ack,
    output logic                 seq_busy,
    output logic                 uop_valid,
    output ucode_pkg::opcode_t   uop_op,
    output ucode_pkg::reg_addr_t uop_rd,
    output ucode_pkg::reg_addr_t uop_rs1,
    output ucode_pkg::reg_addr_t uop_rs2
);
    import ucode_pkg::*;

    seq_state_t state;
    imm_t       add_cnt;   // ADDs still to issue
    reg_addr_t  mul_rd;    // Latched destination
    reg_addr_t  mul_rs1;   // Latched multiplicand register

    // Take a held MUL only when idle
    assign mul_ack  = (state == SEQ_IDLE) && dec_valid && dec_is_mul;
    assign seq_busy = (state != SEQ_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SEQ_IDLE;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (mul_ack) begin
                        state <= SEQ_COPY;
                    end
                end
                SEQ_COPY:  state <= SEQ_CLEAR;
                SEQ_CLEAR: begin
                    // imm of 0 leaves rd cleared and ends here
                    state <= (add_cnt == '0) ? SEQ_IDLE : SEQ_ADD;
                end
                SEQ_ADD: begin
                    if (add_cnt == imm_t'(1)) begin  // Last ADD goes out this cycle
                        state <= SEQ_IDLE;
                    end
                end
                default:   state <= SEQ_IDLE;
            endcase
        end
    end

    // Down-counter, loaded with imm on acknowledge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            add_cnt <= '0;
        end else if (mul_ack) begin
            add_cnt <= dec_imm;
        end else if (state == SEQ_ADD) begin
            add_cnt <= add_cnt - imm_t'(1);
        end
    end

    // Operand registers of the MUL being expanded
    always_ff @(posedge clk) begin
        if (mul_ack) begin
            mul_rd  <= dec_rd;
            mul_rs1 <= dec_rs1;
        end
    end

    // Micro-op for the current state
    always_comb begin
        uop_valid = 1'b0;
        uop_op    = OP_NOP;
        uop_rd    = '0;
        uop_rs1   = '0;
        uop_rs2   = '0;
        case (state)
            SEQ_COPY: begin
                uop_valid = 1'b1;
                uop_op    = OP_MOV;
                uop_rd    = UCODE_SCRATCH;
                uop_rs1   = mul_rs1;  // Saved before rd is touched, so rd == rs1 works
            end
            SEQ_CLEAR: begin
                uop_valid = 1'b1;
                uop_op    = OP_SUB;
                uop_rd    = mul_rd;
                uop_rs1   = mul_rd;
                uop_rs2   = mul_rd;
            end
            SEQ_ADD: begin
                uop_valid = 1'b1;
                uop_op    = OP_ADD;
                uop_rd    = mul_rd;
                uop_rs1   = mul_rd;
                uop_rs2   = UCODE_SCRATCH;
            end
            default: ;  // Idle, nothing to issue
        endcase
    end

endmodule

`default_nettype wire

/* hdl/issue_stage.sv */
/* Issue register between decode and execute.
   Micro-ops win while the sequencer is busy, otherwise a plain decoded instruction goes. */
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  dec_valid,
    input  wire                  dec_is_mul,
    input  ucode_pkg::opcode_t   dec_op,
    input  ucode_pkg::reg_addr_t dec_rd,
    input  ucode_pkg::reg_addr_t dec_rs1,
    input  ucode_pkg::reg_addr_t dec_rs2,
    input  ucode_pkg::imm_t      dec_imm,
    output logic                 dec_ready,
    input  wire                  seq_busy,
    input  wire                  uop_valid,
    input  ucode_pkg::opcode_t   uop_op,
    input  ucode_pkg::reg_addr_t uop_rd,
    input  ucode_pkg::reg_addr_t uop_rs1,
    input  ucode_pkg::reg_addr_t uop_rs2,
    output logic                 iss_valid,
    output ucode_pkg::opcode_t   iss_op,
    output ucode_pkg::reg_addr_t iss_rd,
    output ucode_pkg::reg_addr_t iss_rs1,
    output ucode_pkg::reg_addr_t iss_rs2,
    output ucode_pkg::imm_t      iss_imm
);
    logic take_dec;  // Plain instruction is issued this cycle

    // MUL stays put for the sequencer, decoder waits while busy
    assign take_dec  = dec_valid & ~dec_is_mul & ~seq_busy;
    assign dec_ready = take_dec;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= seq_busy ? uop_valid : take_dec;
        end
    end

    // Operation fields
    always_ff @(posedge clk) begin
        iss_op  <= seq_busy ? uop_op  : dec_op;
        iss_rd  <= seq_busy ? uop_rd  : dec_rd;
        iss_rs1 <= seq_busy ? uop_rs1 : dec_rs1;
        iss_rs2 <= seq_busy ? uop_rs2 : dec_rs2;
        iss_imm <= seq_busy ? '0      : dec_imm;  // Micro-ops are register form
    end

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
/* 16 x 16-bit register file, two combinational read ports and one write port.
   A write lands on the clock edge and is visible to reads in the next cycle. */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                  clk,
    input  wire                  rst,
    input  ucode_pkg::reg_addr_t rd_addr_a,
    input  ucode_pkg::reg_addr_t rd_addr_b,
    output ucode_pkg::data_t     rd_data_a,
    output ucode_pkg::data_t     rd_data_b,
    input  wire                  wr_valid,
    input  ucode_pkg::reg_addr_t wr_reg,
    input  ucode_pkg::data_t     wr_data
);
    import ucode_pkg::*;

    data_t regs [NUM_REGS];

    // All registers start from zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            regs[wr_reg] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];  // rs1 port
    assign rd_data_b = regs[rd_addr_b];  // rs2 port

endmodule

`default_nettype wire

/* hdl/exec_alu.sv */
/* Execute stage, reads operands and produces the write-back for the issued operation.
   The write-back feeds the register file and the observation ports of the top. */
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  wire                  iss_valid,
    input  ucode_pkg::opcode_t   iss_op,
    input  ucode_pkg::reg_addr_t iss_rd,
    input  ucode_pkg::reg_addr_t iss_rs1,
    input  ucode_pkg::reg_addr_t iss_rs2,
    input  ucode_pkg::imm_t      iss_imm,
    output ucode_pkg::reg_addr_t rd_addr_a,
    output ucode_pkg::reg_addr_t rd_addr_b,
    input  ucode_pkg::data_t     rd_data_a,
    input  ucode_pkg::data_t     rd_data_b,
    output logic                 wr_valid,
    output ucode_pkg::reg_addr_t wr_reg,
    output ucode_pkg::data_t     wr_data
);
    import ucode_pkg::*;

    logic writes;  // Opcode produces a result

    assign rd_addr_a = iss_rs1;
    assign rd_addr_b = iss_rs2;
    assign wr_reg    = iss_rd;
    assign wr_valid  = iss_valid & writes;

    // Results wrap at 16 bits
    always_comb begin
        writes  = 1'b1;
        wr_data = '0;
        case (iss_op)
            OP_MOVI: wr_data = data_t'(iss_imm);
            OP_MOV:  wr_data = rd_data_a;
            OP_ADD:  wr_data = rd_data_a + rd_data_b;
            OP_SUB:  wr_data = rd_data_a - rd_data_b;
            OP_NOP:  writes  = 1'b0;
            default: writes  = 1'b0;  // Unknown opcodes, and a stray MUL, act as NOP
        endcase
    end

endmodule

`default_nettype wire

/* hdl/ucode_core.sv */
/* Top of the execution slice, wiring decoder, sequencer, issue, register file and ALU.
   Instructions enter on valid/ready, every register write shows on the wr_* ports. */
`timescale 1ns/1ps
`default_nettype none

module ucode_core (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  in_valid,
    output logic                 in_ready,
    input  ucode_pkg::instr_t    in_instr,
    output logic                 wr_valid,
    output ucode_pkg::reg_addr_t wr_reg,
    output ucode_pkg::data_t     wr_data
);
    import ucode_pkg::*;

    // Decoder outputs
    logic      dec_valid, dec_is_mul, dec_ready;
    opcode_t   dec_op;
    reg_addr_t dec_rd, dec_rs1, dec_rs2;
    imm_t      dec_imm;

    // Sequencer outputs
    logic      mul_ack, seq_busy, uop_valid;
    opcode_t   uop_op;
    reg_addr_t uop_rd, uop_rs1, uop_rs2;

    // Issue register
    logic      iss_valid;
    opcode_t   iss_op;
    reg_addr_t iss_rd, iss_rs1, iss_rs2;
    imm_t      iss_imm;

    // Register file read ports
    reg_addr_t rd_addr_a, rd_addr_b;
    data_t     rd_data_a, rd_data_b;

    instr_decoder decoder_i (
        .clk, .rst, .in_valid, .in_ready, .in_instr,
        .dec_ready, .mul_ack, .dec_valid, .dec_is_mul,
        .dec_op, .dec_rd, .dec_rs1, .dec_rs2, .dec_imm
    );

    ucode_sequencer sequencer_i (
        .clk, .rst, .dec_valid, .dec_is_mul, .dec_rd, .dec_rs1, .dec_imm,
        .mul_ack, .seq_busy, .uop_valid, .uop_op, .uop_rd, .uop_rs1, .uop_rs2
    );

    issue_stage issue_i (
        .clk, .rst, .dec_valid, .dec_is_mul, .dec_op, .dec_rd, .dec_rs1,
        .dec_rs2, .dec_imm, .dec_ready, .seq_busy, .uop_valid, .uop_op,
        .uop_rd, .uop_rs1, .uop_rs2, .iss_valid, .iss_op, .iss_rd,
        .iss_rs1, .iss_rs2, .iss_imm
    );

    reg_file regs_i (
        .clk, .rst, .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .wr_valid, .wr_reg, .wr_data
    );

    // Write-back goes to the register file and out of the top
    exec_alu alu_i (
        .iss_valid, .iss_op, .iss_rd, .iss_rs1, .iss_rs2, .iss_imm,
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .wr_valid, .wr_reg, .wr_data
    );

endmodule

`default_nettype wire

/* tb/ucode_core_sva.sv */
/* Concurrent checks on the input handshake, the write-back port and the micro-op stream.
   Bound into ucode_core, reports only through failing assertions. */
`timescale 1ns/1ps
`default_nettype none

module ucode_core_sva (
    input wire                  clk,
    input wire                  rst,
    input wire                  in_valid,
    input wire                  in_ready,
    input ucode_pkg::instr_t    in_instr,
    input wire                  wr_valid,
    input ucode_pkg::reg_addr_t wr_reg,
    input wire                  seq_busy,
    input wire                  uop_valid
);
    // Nothing is written back while reset is held
    wr_quiet_in_reset: assert property (@(posedge clk) rst |-> !wr_valid)
        else $error("write-back seen during reset");

    // Offered instruction stays put until it is taken
    in_hold_until_taken: assert property (@(posedge clk) disable iff (rst)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_instr)))
        else $error("in_valid or in_instr changed before the transfer");

    wr_reg_known: assert property (@(posedge clk) disable iff (rst)
        wr_valid |-> !$isunknown(wr_reg))
        else $error("wr_reg unknown during a write-back");

    // Micro-ops only come out of a running expansion
    uop_needs_busy: assert property (@(posedge clk) disable iff (rst)
        uop_valid |-> seq_busy)
        else $error("micro-op valid while the sequencer is idle");

endmodule

bind ucode_core ucode_core_sva sva_i (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
    .wr_valid(wr_valid), .wr_reg(wr_reg), .seq_busy(seq_busy), .uop_valid(uop_valid)
);

`default_nettype wire

/* tb/ucode_core_tb.sv */
/* Directed testbench for ucode_core with a reference register model.
   Each test sends instructions on valid/ready and compares every write-back in order. */
`timescale 1ns/1ps
`default_nettype none

module ucode_core_tb;
    import ucode_pkg::*;

    logic      clk;
    logic      rst;
    logic      in_valid;
    logic      in_ready;
    instr_t    in_instr;
    logic      wr_valid;
    reg_addr_t wr_reg;
    data_t     wr_data;

    data_t     ref_regs [16];  // Reference register model
    reg_addr_t exp_reg[$];
    data_t     exp_data[$];
    reg_addr_t obs_reg[$];
    data_t     obs_data[$];
    int        obs_cyc[$];     // Edge that commits each write-back
    int        acc_cyc[$];     // Edge that accepted each instruction
    int        cyc = 0;
    int        last_stall;     // Cycles the last send waited for in_ready
    int        errors;
    int        checks;
    int        tests;
    int        seed;

    ucode_core dut_i (
        .clk, .rst, .in_valid, .in_ready, .in_instr, .wr_valid, .wr_reg, .wr_data
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Write-back monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && wr_valid) begin
            obs_reg.push_back(wr_reg);
            obs_data.push_back(wr_data);
            obs_cyc.push_back(cyc + 1);
        end
    end

    task automatic check_cond(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("FAILED at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    function automatic data_t rand_data();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic reg_addr_t rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[3:0];
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    function automatic instr_t encode_instr(input opcode_t op, input reg_addr_t rd,
                                            input reg_addr_t rs1, input reg_addr_t rs2,
                                            input imm_t imm);
        instr_t w;
        w = '0;
        w[31:26] = op;
        w[RD_LSB +: 4]  = rd;
        w[RS1_LSB +: 4] = rs1;
        if (op == OP_MOVI || op == OP_MUL) begin
            w[15:0] = imm;  // Immediate form
        end else begin
            w[RS2_LSB +: 4] = rs2;
        end
        return w;
    endfunction

    task automatic model_write(input reg_addr_t rd, input data_t val);
        ref_regs[rd] = val;
        exp_reg.push_back(rd);
        exp_data.push_back(val);
    endtask

    // Expected write-backs of one instruction, in execution order
    task automatic model_exec(input opcode_t op, input reg_addr_t rd, input reg_addr_t rs1,
                              input reg_addr_t rs2, input imm_t imm);
        case (op)
            OP_MOVI: model_write(rd, imm);
            OP_MOV:  model_write(rd, ref_regs[rs1]);
            OP_ADD:  model_write(rd, ref_regs[rs1] + ref_regs[rs2]);
            OP_SUB:  model_write(rd, ref_regs[rs1] - ref_regs[rs2]);
            OP_MUL: begin
                model_write(4'd15, ref_regs[rs1]);  // Scratch copy
                model_write(rd, 16'd0);             // Clear rd
                for (int i = 0; i < int'(imm); i++) begin
                    model_write(rd, ref_regs[rd] + ref_regs[4'd15]);
                end
            end
            default: ;  // NOP and unknown opcodes
        endcase
    endtask

    task automatic send_instr(input opcode_t op, input reg_addr_t rd, input reg_addr_t rs1,
                              input reg_addr_t rs2, input imm_t imm);
        int waited;
        bit taken;
        waited = 0;
        taken  = 1'b0;
        model_exec(op, rd, rs1, rs2, imm);
        in_instr = encode_instr(op, rd, rs1, rs2, imm);
        in_valid = 1'b1;
        while (!taken && waited < 200) begin
            @(negedge clk);
            if (in_ready) begin
                taken = 1'b1;  // Transfer on the coming edge
            end else begin
                waited++;
            end
        end
        if (taken) begin
            acc_cyc.push_back(cyc + 1);
        end else begin
            $display("Timeout at %0t: in_ready stayed low for %0d cycles", $time, waited);
            errors++;
        end
        @(posedge clk);
        #0.5;
        in_valid   = 1'b0;
        last_stall = waited;
    endtask

    task automatic collect_writebacks();
        int waited;
        int n;
        waited = 0;
        while (obs_reg.size() < exp_reg.size() && waited < 400) begin
            @(posedge clk);
            waited++;
        end
        if (obs_reg.size() < exp_reg.size()) begin
            $display("Timeout at %0t: only %0d of %0d write-backs arrived",
                     $time, obs_reg.size(), exp_reg.size());
            errors++;
        end
        repeat (3) @(posedge clk);  // Drain, any stray write-back shows up
        #0.5;
        check_cond(obs_reg.size() == exp_reg.size(),
                   $sformatf("%0d write-backs, expected %0d", obs_reg.size(), exp_reg.size()));
        n = (obs_reg.size() < exp_reg.size()) ? obs_reg.size() : exp_reg.size();
        for (int i = 0; i < n; i++) begin
            check_cond(obs_reg[i] == exp_reg[i] && obs_data[i] == exp_data[i],
                       $sformatf("write-back %0d is R%0d=%h, expected R%0d=%h",
                                 i, obs_reg[i], obs_data[i], exp_reg[i], exp_data[i]));
        end
    endtask

    task automatic clear_queues();
        exp_reg.delete();
        exp_data.delete();
        obs_reg.delete();
        obs_data.delete();
        obs_cyc.delete();
        acc_cyc.delete();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("%s: done, %0d errors", name, errors - errors_before);
        clear_queues();
    endtask

    task automatic reset_and_movi();
        int e0;
        e0 = errors;
        check_cond(in_ready === 1'b1, "in_ready low after reset");
        check_cond(wr_valid === 1'b0 && obs_reg.size() == 0, "write-back without input");
        clear_queues();
        send_instr(OP_MOVI, 4'd1, 4'd0, 4'd0, 16'h1234);
        send_instr(OP_MOVI, 4'd2, 4'd0, 4'd0, 16'hffff);
        send_instr(OP_MOVI, 4'd3, 4'd0, 4'd0, 16'h0001);
        send_instr(OP_MOVI, 4'd15, 4'd0, 4'd0, 16'h8000);
        collect_writebacks();
        finish_test("movi after reset", e0);
    endtask

    task automatic alu_ops();
        int e0;
        e0 = errors;
        send_instr(OP_MOVI, 4'd1, 4'd0, 4'd0, rand_data());
        send_instr(OP_MOVI, 4'd2, 4'd0, 4'd0, rand_data());
        send_instr(OP_MOVI, 4'd3, 4'd0, 4'd0, 16'hfff0);
        send_instr(OP_MOVI, 4'd4, 4'd0, 4'd0, 16'h0020);
        send_instr(OP_MOV, 4'd5, 4'd1, 4'd0, 16'd0);
        send_instr(OP_ADD, 4'd6, 4'd1, 4'd2, 16'd0);
        send_instr(OP_SUB, 4'd7, 4'd2, 4'd1, 16'd0);
        send_instr(OP_ADD, 4'd8, 4'd3, 4'd4, 16'd0);  // Wraps past 16 bits
        send_instr(OP_SUB, 4'd9, 4'd0, 4'd4, 16'd0);  // Wraps below zero
        collect_writebacks();
        clear_queues();
        // Dependent pair, second reads the first one's result
        send_instr(OP_MOVI, 4'd10, 4'd0, 4'd0, 16'h0abc);
        send_instr(OP_ADD, 4'd11, 4'd10, 4'd10, 16'd0);
        collect_writebacks();
        if (acc_cyc.size() == 2 && obs_cyc.size() == 2) begin
            check_cond(acc_cyc[1] == acc_cyc[0] + 1, "dependent pair was stalled");
            check_cond(obs_cyc[0] - acc_cyc[0] == 2 && obs_cyc[1] - acc_cyc[1] == 2,
                       "write-back not 2 cycles after acceptance");
        end
        finish_test("alu ops and dependent pair", e0);
    endtask

    task automatic mul_and_check(input reg_addr_t rd, input reg_addr_t rs1, input imm_t imm,
                                 input data_t val);
        data_t product;
        product = val * data_t'(imm);  // Modulo 2^16
        send_instr(OP_MOVI, rs1, 4'd0, 4'd0, val);
        collect_writebacks();
        clear_queues();
        send_instr(OP_MUL, rd, rs1, 4'd0, imm);
        collect_writebacks();
        for (int i = 1; i < obs_cyc.size(); i++) begin
            check_cond(obs_cyc[i] == obs_cyc[i-1] + 1,
                       $sformatf("MUL write-back %0d not on the next cycle", i));
        end
        if (obs_data.size() > 0) begin
            check_cond(obs_reg[$] == rd && obs_data[$] == product,
                       $sformatf("MUL result R%0d=%h, expected R%0d=%h",
                                 obs_reg[$], obs_data[$], rd, product));
        end
        clear_queues();
    endtask

    task automatic mul_small_imm();
        int e0;
        e0 = errors;
        mul_and_check(4'd6, 4'd2, 16'd0, rand_data());
        mul_and_check(4'd7, 4'd3, 16'd1, rand_data());
        mul_and_check(4'd8, 4'd1, 16'd5, rand_data());
        finish_test("mul with imm 0, 1 and 5", e0);
    endtask

    task automatic mul_rd_is_rs1();
        int e0;
        e0 = errors;
        mul_and_check(4'd3, 4'd3, 16'd4, rand_data());
        finish_test("mul with rd equal to rs1", e0);
    endtask

    task automatic mul_backpressure();
        int   e0;
        imm_t imm;
        e0  = errors;
        imm = imm_t'(30 + rand_below(30));
        send_instr(OP_MOVI, 4'd2, 4'd0, 4'd0, rand_data());
        send_instr(OP_MUL, 4'd4, 4'd2, 4'd0, imm);
        send_instr(OP_MOV, 4'd5, 4'd4, 4'd0, 16'd0);  // Held behind the MUL
        send_instr(OP_ADD, 4'd6, 4'd5, 4'd2, 16'd0);
        check_cond(last_stall >= int'(imm),
                   $sformatf("input stalled %0d cycles during a MUL of %0d", last_stall, imm));
        send_instr(OP_SUB, 4'd7, 4'd6, 4'd4, 16'd0);
        collect_writebacks();
        finish_test("back-pressure during mul", e0);
    endtask

    task automatic random_mix();
        int      e0;
        int      k;
        opcode_t op;
        imm_t    imm;
        e0 = errors;
        for (int i = 0; i < 40; i++) begin
            k   = rand_below(7);
            imm = rand_data();
            case (k)
                0:       op = OP_NOP;
                1:       op = OP_MOVI;
                2:       op = OP_MOV;
                3:       op = OP_ADD;
                4:       op = OP_SUB;
                5: begin
                    op  = OP_MUL;
                    imm = imm_t'(rand_below(4));  // Short expansions
                end
                default: op = 6'h3f;  // Undefined opcode
            endcase
            send_instr(op, rand_reg(), rand_reg(), rand_reg(), imm);
        end
        collect_writebacks();
        finish_test("random mix", e0);
    endtask

    initial begin
        seed       = 32'ha8fc85cb;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        last_stall = 0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_instr   = '0;
        for (int i = 0; i < 16; i++) begin
            ref_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #0.5;
        rst = 1'b0;
        @(posedge clk);
        #0.5;
        reset_and_movi();
        alu_ops();
        mul_small_imm();
        mul_rd_is_rs1();
        mul_backpressure();
        random_mix();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
common/ucode_pkg.sv
hdl/instr_decoder.sv
ucode/ucode_sequencer.sv
hdl/issue_stage.sv
hdl/reg_file.sv
hdl/exec_alu.sv
hdl/ucode_core.sv
tb/ucode_core_sva.sv
tb/ucode_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the ucode_core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ucode_core_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vucode_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
